/* hdl/cpu_frontend_settings.svh */
`ifndef CPU_FRONTEND_SETTINGS_SVH
`define CPU_FRONTEND_SETTINGS_SVH

// Byte address width for ROM, memory and instruction pointers.
`define ADDR_W 16

// Operands are 32-bit little-endian words.
`define OPERAND_W 32
`define OPERAND_BYTES 4

// One operation byte plus two operands.
`define INSTR_BYTES 9

// On-chip program memory in bytes.
`define MEM_DEPTH 256

// First occurrence of this byte opens the code section.
`define CODE_MARKER 8'hC0

// Interrupt vectors and queue.
`define NUM_IRQ 4
`define IRQ_KEY 0
`define IRQ_DEPTH 4

`endif

/* hdl/cpu_frontend_pkg.sv */
`include "cpu_frontend_settings.svh"

package cpu_frontend_pkg;

    // Sequencer states.
    typedef enum logic [2:0] {
        LOAD,
        FETCH,
        ISSUE,
        ADVANCE,
        IRQ_CHECK,
        IRQ_ENTER
    } fe_state_t;

    // One assembled instruction, operation in the top byte.
    typedef struct packed {
        logic [7:0]            operation;
        logic [`OPERAND_W-1:0] operand1;
        logic [`OPERAND_W-1:0] operand2;
    } instr_t;

    // One pending interrupt.
    typedef struct packed {
        logic [1:0]            irq_type;
        logic [`OPERAND_W-1:0] value;   // Scancode, zero-extended.
    } irq_entry_t;

endpackage

/* hdl/frontend_fsm.sv */
`timescale 1ns/1ps
`include "cpu_frontend_settings.svh"

module frontend_fsm (
    input  logic                        CLOCK_50,
    input  logic                        rst_n_i,
    input  logic                        rom_done_i,
    input  logic [7:0]                  rom_byte_i,
    input  logic [`ADDR_W-1:0]          byte_idx_i,
    input  logic                        queue_empty_i,
    input  logic                        isr_active_i,
    input  logic                        iret_i,
    output cpu_frontend_pkg::fe_state_t state_o,
    output logic                        cnt_clear_o,
    output logic                        cnt_step_o,
    output logic                        mem_we_o,
    output logic                        mem_rd_o,
    output logic                        shift_o,
    output logic                        set_code_start_o,
    output logic                        advance_o,
    output logic                        enter_irq_o,
    output logic                        pop_o,
    output logic                        instr_valid_o
);
    import cpu_frontend_pkg::*;

    fe_state_t state_q;
    fe_state_t state_d;
    logic      marker_found_q;
    logic      capture_q;       // Second cycle of a byte fetch.
    logic      last_byte;
    logic      restart;

    assign last_byte = (byte_idx_i == `ADDR_W'(`INSTR_BYTES - 1));
    // Return from a routine throws away the fetch under way.
    assign restart   = iret_i && isr_active_i && (state_q != LOAD);
    assign state_o   = state_q;

    always_comb
    begin
        state_d          = state_q;
        cnt_clear_o      = 1'b0;
        cnt_step_o       = 1'b0;
        mem_we_o         = 1'b0;
        mem_rd_o         = 1'b0;
        shift_o          = 1'b0;
        set_code_start_o = 1'b0;
        advance_o        = 1'b0;
        enter_irq_o      = 1'b0;
        pop_o            = 1'b0;
        instr_valid_o    = 1'b0;
        case (state_q)
            LOAD:
            begin
                if (rom_done_i)
                begin
                    cnt_clear_o = 1'b1;
                    state_d     = FETCH;
                end
                else
                begin
                    mem_we_o         = 1'b1;
                    cnt_step_o       = 1'b1;
                    set_code_start_o = !marker_found_q && (rom_byte_i == `CODE_MARKER);
                end
            end
            FETCH:
            begin
                if (!capture_q)
                begin
                    mem_rd_o = 1'b1;
                end
                else
                begin
                    shift_o    = 1'b1;
                    cnt_step_o = 1'b1;
                    if (last_byte)
                    begin
                        state_d = ISSUE;
                    end
                end
            end
            ISSUE:
            begin
                instr_valid_o = 1'b1;
                cnt_clear_o   = 1'b1;
                state_d       = ADVANCE;
            end
            ADVANCE:
            begin
                advance_o = 1'b1;
                state_d   = IRQ_CHECK;
            end
            IRQ_CHECK:
            begin
                // Only one routine runs at a time.
                state_d = (!queue_empty_i && !isr_active_i) ? IRQ_ENTER : FETCH;
            end
            IRQ_ENTER:
            begin
                enter_irq_o = 1'b1;
                pop_o       = 1'b1;
                state_d     = FETCH;
            end
            default:
            begin
                state_d = LOAD;
            end
        endcase

        if (restart)
        begin
            state_d     = FETCH;
            cnt_clear_o = 1'b1;
            cnt_step_o  = 1'b0;
            mem_rd_o    = 1'b0;
            shift_o     = 1'b0;
            advance_o   = 1'b0;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q        <= LOAD;
            marker_found_q <= 1'b0;
            capture_q      <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (set_code_start_o)
            begin
                marker_found_q <= 1'b1;
            end
            if (restart || state_q != FETCH)
            begin
                capture_q <= 1'b0;
            end
            else
            begin
                capture_q <= !capture_q;
            end
        end
    end

endmodule

/* hdl/byte_counter.sv */
`timescale 1ns/1ps
`include "cpu_frontend_settings.svh"

module byte_counter (
    input  logic               CLOCK_50,
    input  logic               rst_n_i,
    input  logic               clear_i,
    input  logic               step_i,
    output logic [`ADDR_W-1:0] count_o
);

    // Load address during LOAD, byte index within the instruction afterwards.
    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            count_o <= '0;
        end
        else if (clear_i)
        begin
            count_o <= '0;
        end
        else if (step_i)
        begin
            count_o <= count_o + `ADDR_W'(1);
        end
    end

endmodule

/* hdl/program_ram.sv */
`timescale 1ns/1ps
`include "cpu_frontend_settings.svh"

module program_ram (
    input  logic               CLOCK_50,
    input  logic               we_i,
    input  logic [`ADDR_W-1:0] wr_addr_i,
    input  logic [7:0]         wr_data_i,
    input  logic               rd_i,
    input  logic [`ADDR_W-1:0] rd_addr_i,
    output logic [7:0]         rd_data_o
);

    localparam int AW = $clog2(`MEM_DEPTH);

    logic [7:0] mem [`MEM_DEPTH];

    // Addresses wrap at the array size.
    always_ff @(posedge CLOCK_50)
    begin
        if (we_i)
        begin
            mem[wr_addr_i[AW-1:0]] <= wr_data_i;
        end
        if (rd_i)
        begin
            rd_data_o <= mem[rd_addr_i[AW-1:0]];
        end
    end

endmodule

/* hdl/instr_assembler.sv */
`timescale 1ns/1ps
`include "cpu_frontend_settings.svh"

module instr_assembler (
    input  logic                     CLOCK_50,
    input  logic                     rst_n_i,
    input  logic                     shift_i,
    input  logic [`ADDR_W-1:0]       byte_idx_i,
    input  logic [7:0]               byte_i,
    output cpu_frontend_pkg::instr_t instr_o
);

    logic [7:0]            operation_q;
    logic [`OPERAND_W-1:0] operand1_q;
    logic [`OPERAND_W-1:0] operand2_q;

    // Operands fill from the top, so the first byte ends up lowest.
    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            operation_q <= '0;
            operand1_q  <= '0;
            operand2_q  <= '0;
        end
        else if (shift_i)
        begin
            if (byte_idx_i == '0)
            begin
                operation_q <= byte_i;
            end
            else if (byte_idx_i <= `ADDR_W'(`OPERAND_BYTES))
            begin
                operand1_q <= {byte_i, operand1_q[`OPERAND_W-1:8]};
            end
            else
            begin
                operand2_q <= {byte_i, operand2_q[`OPERAND_W-1:8]};
            end
        end
    end

    assign instr_o = '{operation: operation_q, operand1: operand1_q, operand2: operand2_q};

endmodule

/* hdl/irq_queue.sv */
`timescale 1ns/1ps
`include "cpu_frontend_settings.svh"

module irq_queue (
    input  logic                         CLOCK_50,
    input  logic                         rst_n_i,
    input  logic                         push_i,
    input  logic [7:0]                   scancode_i,
    input  logic                         pop_i,
    output cpu_frontend_pkg::irq_entry_t head_o,
    output logic                         empty_o
);
    import cpu_frontend_pkg::*;

    localparam int PW = $clog2(`IRQ_DEPTH);

    irq_entry_t    entries [`IRQ_DEPTH];
    irq_entry_t    new_entry;
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [PW:0]   count_q;
    logic          do_push;
    logic          do_pop;

    assign new_entry = '{irq_type: 2'(`IRQ_KEY), value: {{(`OPERAND_W-8){1'b0}}, scancode_i}};

    assign empty_o = (count_q == '0);
    // A scancode that finds the queue full is lost.
    assign do_push = push_i && (count_q != (PW+1)'(`IRQ_DEPTH));
    assign do_pop  = pop_i && !empty_o;
    assign head_o  = entries[rd_ptr_q];

    always_ff @(posedge CLOCK_50)
    begin
        if (do_push)
        begin
            entries[wr_ptr_q] <= new_entry;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PW+1)'(do_push) - (PW+1)'(do_pop);
        end
    end

endmodule

/* hdl/ip_unit.sv */
`timescale 1ns/1ps
`include "cpu_frontend_settings.svh"

module ip_unit (
    input  logic                         CLOCK_50,
    input  logic                         rst_n_i,
    input  logic                         set_code_start_i,
    input  logic [`ADDR_W-1:0]           start_addr_i,
    input  logic                         advance_i,
    input  logic                         enter_irq_i,
    input  cpu_frontend_pkg::irq_entry_t irq_i,
    input  logic                         iret_i,
    input  logic                         vector_we_i,
    input  logic [1:0]                   vector_idx_i,
    input  logic [`ADDR_W-1:0]           vector_addr_i,
    output logic [`ADDR_W-1:0]           ip_o,
    output logic                         isr_active_o,
    output logic [`OPERAND_W-1:0]        isr_value_o
);

    logic [`ADDR_W-1:0] saved_ip_q;
    logic [`ADDR_W-1:0] code_start_q;
    logic [`ADDR_W-1:0] vector_q [`NUM_IRQ];
    logic [`ADDR_W-1:0] first_code;

    // Code starts right after the marker byte.
    assign first_code = start_addr_i + `ADDR_W'(1);

    always_ff @(posedge CLOCK_50 or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ip_o         <= '0;
            saved_ip_q   <= '0;
            code_start_q <= '0;
            isr_active_o <= 1'b0;
            isr_value_o  <= '0;
            for (int i = 0; i < `NUM_IRQ; i++)
            begin
                vector_q[i] <= '0;
            end
        end
        else
        begin
            if (vector_we_i)
            begin
                vector_q[vector_idx_i] <= vector_addr_i;
            end

            if (set_code_start_i)
            begin
                code_start_q <= first_code;
                ip_o         <= first_code;
            end
            else if (enter_irq_i)
            begin
                // The pointer was already advanced past the last instruction.
                saved_ip_q   <= ip_o;
                ip_o         <= code_start_q + vector_q[irq_i.irq_type];
                isr_active_o <= 1'b1;
                isr_value_o  <= irq_i.value;
            end
            else if (iret_i && isr_active_o)
            begin
                ip_o         <= saved_ip_q;
                isr_active_o <= 1'b0;
            end
            else if (advance_i)
            begin
                ip_o <= ip_o + `ADDR_W'(`INSTR_BYTES);
            end
        end
    end

endmodule

/* hdl/cpu_frontend.sv */
`timescale 1ns/1ps
`include "cpu_frontend_settings.svh"

module cpu_frontend (
    input  logic                     CLOCK_50,
    input  logic                     rst_n_i,
    output logic [`ADDR_W-1:0]       rom_addr_o,
    input  logic [7:0]               rom_byte_i,
    input  logic                     rom_done_i,
    input  logic [7:0]               scancode_i,
    input  logic                     scancode_valid_i,
    input  logic                     vector_we_i,
    input  logic [1:0]               vector_idx_i,
    input  logic [`ADDR_W-1:0]       vector_addr_i,
    input  logic                     iret_i,
    output logic                     instr_valid_o,
    output cpu_frontend_pkg::instr_t instr_o,
    output logic [`ADDR_W-1:0]       instr_ip_o,
    output logic                     isr_active_o,
    output logic [`OPERAND_W-1:0]    isr_value_o
);
    import cpu_frontend_pkg::*;

    logic               cnt_clear;
    logic               cnt_step;
    logic               mem_we;
    logic               mem_rd;
    logic               shift;
    logic               set_code_start;
    logic               advance;
    logic               enter_irq;
    logic               pop;
    logic [`ADDR_W-1:0] byte_cnt;
    logic [`ADDR_W-1:0] ip;
    logic [7:0]         rd_data;
    logic               queue_empty;
    logic               isr_active;
    irq_entry_t         irq_head;

    // The counter is the ROM address during load.
    assign rom_addr_o   = byte_cnt;
    assign instr_ip_o   = ip;
    assign isr_active_o = isr_active;

    frontend_fsm i_frontend_fsm (
        .CLOCK_50         (CLOCK_50),
        .rst_n_i          (rst_n_i),
        .rom_done_i       (rom_done_i),
        .rom_byte_i       (rom_byte_i),
        .byte_idx_i       (byte_cnt),
        .queue_empty_i    (queue_empty),
        .isr_active_i     (isr_active),
        .iret_i           (iret_i),
        .state_o          (),
        .cnt_clear_o      (cnt_clear),
        .cnt_step_o       (cnt_step),
        .mem_we_o         (mem_we),
        .mem_rd_o         (mem_rd),
        .shift_o          (shift),
        .set_code_start_o (set_code_start),
        .advance_o        (advance),
        .enter_irq_o      (enter_irq),
        .pop_o            (pop),
        .instr_valid_o    (instr_valid_o)
    );

    byte_counter i_byte_counter (
        .CLOCK_50 (CLOCK_50),
        .rst_n_i  (rst_n_i),
        .clear_i  (cnt_clear),
        .step_i   (cnt_step),
        .count_o  (byte_cnt)
    );

    program_ram i_program_ram (
        .CLOCK_50  (CLOCK_50),
        .we_i      (mem_we),
        .wr_addr_i (byte_cnt),
        .wr_data_i (rom_byte_i),
        .rd_i      (mem_rd),
        .rd_addr_i (ip + byte_cnt),
        .rd_data_o (rd_data)
    );

    instr_assembler i_instr_assembler (
        .CLOCK_50   (CLOCK_50),
        .rst_n_i    (rst_n_i),
        .shift_i    (shift),
        .byte_idx_i (byte_cnt),
        .byte_i     (rd_data),
        .instr_o    (instr_o)
    );

    irq_queue i_irq_queue (
        .CLOCK_50   (CLOCK_50),
        .rst_n_i    (rst_n_i),
        .push_i     (scancode_valid_i),
        .scancode_i (scancode_i),
        .pop_i      (pop),
        .head_o     (irq_head),
        .empty_o    (queue_empty)
    );

    ip_unit i_ip_unit (
        .CLOCK_50         (CLOCK_50),
        .rst_n_i          (rst_n_i),
        .set_code_start_i (set_code_start),
        .start_addr_i     (byte_cnt),
        .advance_i        (advance),
        .enter_irq_i      (enter_irq),
        .irq_i            (irq_head),
        .iret_i           (iret_i),
        .vector_we_i      (vector_we_i),
        .vector_idx_i     (vector_idx_i),
        .vector_addr_i    (vector_addr_i),
        .ip_o             (ip),
        .isr_active_o     (isr_active),
        .isr_value_o      (isr_value_o)
    );

endmodule

/* sim/tb_cpu_frontend.sv */
`timescale 1ns/1ps
`include "cpu_frontend_settings.svh"

module tb_cpu_frontend;
    import cpu_frontend_pkg::*;

    localparam int NUM_INSTR       = 4;
    localparam int IMG_LEN         = 3 + NUM_INSTR * `INSTR_BYTES;
    localparam int NUM_ROWS        = 5;
    // The key routine starts at the fourth instruction.
    localparam int VEC_OFFSET      = 3 * `INSTR_BYTES;
    localparam int IRET_GAP        = 5;
    localparam int WATCHDOG_CYCLES = 40 * NUM_ROWS + IMG_LEN + 100;

    typedef struct packed {
        logic                  vec_we;
        logic [`ADDR_W-1:0]    vec_addr;
        logic                  send_scan;
        logic [7:0]            scan;
        logic                  do_iret;
        logic [1:0]            slot;
        logic                  exp_active;
        logic [`OPERAND_W-1:0] exp_value;
    } row_t;

    logic                  CLOCK_50;
    logic                  rst_n_i;
    logic [`ADDR_W-1:0]    rom_addr_o;
    logic [7:0]            rom_byte_i;
    logic                  rom_done_i;
    logic [7:0]            scancode_i;
    logic                  scancode_valid_i;
    logic                  vector_we_i;
    logic [1:0]            vector_idx_i;
    logic [`ADDR_W-1:0]    vector_addr_i;
    logic                  iret_i;
    logic                  instr_valid_o;
    instr_t                instr_o;
    logic [`ADDR_W-1:0]    instr_ip_o;
    logic                  isr_active_o;
    logic [`OPERAND_W-1:0] isr_value_o;

    logic [7:0]         image [IMG_LEN];
    instr_t             exp_instr [NUM_INSTR];
    logic [`ADDR_W-1:0] exp_ip [NUM_INSTR];
    row_t               rows [NUM_ROWS];
    logic [7:0]         scan1;
    logic [7:0]         scan2;

    cpu_frontend i_cpu_frontend (
        .CLOCK_50         (CLOCK_50),
        .rst_n_i          (rst_n_i),
        .rom_addr_o       (rom_addr_o),
        .rom_byte_i       (rom_byte_i),
        .rom_done_i       (rom_done_i),
        .scancode_i       (scancode_i),
        .scancode_valid_i (scancode_valid_i),
        .vector_we_i      (vector_we_i),
        .vector_idx_i     (vector_idx_i),
        .vector_addr_i    (vector_addr_i),
        .iret_i           (iret_i),
        .instr_valid_o    (instr_valid_o),
        .instr_o          (instr_o),
        .instr_ip_o       (instr_ip_o),
        .isr_active_o     (isr_active_o),
        .isr_value_o      (isr_value_o)
    );

    always #5 CLOCK_50 = ~CLOCK_50;

    // ROM model answers for the address presented by the DUT.
    always @(negedge CLOCK_50)
    begin : rom_model
        int a;
        a = int'(rom_addr_o);
        rom_done_i = (a >= IMG_LEN);
        rom_byte_i = (a < IMG_LEN) ? image[a] : 8'h00;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // Two filler bytes, the marker, then the instructions.
    task automatic build_image();
        logic [7:0] b;
        for (int i = 0; i < 2; i++)
        begin
            b = 8'($urandom);
            while (b == `CODE_MARKER)
            begin
                b = 8'($urandom);
            end
            image[i] = b;
        end
        image[2] = `CODE_MARKER;
        for (int i = 3; i < IMG_LEN; i++)
        begin
            image[i] = 8'($urandom);
        end
        // A later marker value inside an operand.
        image[3 + `INSTR_BYTES + 3] = `CODE_MARKER;
    endtask

    // Little-endian operands: the first byte is the low byte.
    task automatic build_expected();
        int                    code_start;
        int                    base;
        logic [`OPERAND_W-1:0] op1;
        logic [`OPERAND_W-1:0] op2;
        code_start = -1;
        for (int i = 0; i < IMG_LEN; i++)
        begin
            if (code_start < 0 && image[i] == `CODE_MARKER)
            begin
                code_start = i + 1;
            end
        end
        for (int n = 0; n < NUM_INSTR; n++)
        begin
            base = code_start + n * `INSTR_BYTES;
            for (int k = 0; k < `OPERAND_BYTES; k++)
            begin
                op1[8*k +: 8] = image[base + 1 + k];
                op2[8*k +: 8] = image[base + 1 + `OPERAND_BYTES + k];
            end
            exp_ip[n]    = `ADDR_W'(base);
            exp_instr[n] = '{operation: image[base], operand1: op1, operand2: op2};
        end
    endtask

    function automatic row_t make_row(input logic vec_we, input logic send_scan,
                                      input logic [7:0] scan, input logic do_iret,
                                      input logic [1:0] slot, input logic exp_active,
                                      input logic [7:0] exp_scan);
        row_t r;
        r.vec_we     = vec_we;
        r.vec_addr   = `ADDR_W'(VEC_OFFSET);
        r.send_scan  = send_scan;
        r.scan       = scan;
        r.do_iret    = do_iret;
        r.slot       = slot;
        r.exp_active = exp_active;
        r.exp_value  = `OPERAND_W'(exp_scan);
        return r;
    endfunction

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("Timed out waiting for an instruction strobe from the DUT");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    initial
    begin : stimulus
        row_t row;
        void'($urandom(44));
        CLOCK_50         = 1'b0;
        rst_n_i          = 1'b0;
        rom_done_i       = 1'b0;
        scancode_i       = 8'h00;
        scancode_valid_i = 1'b0;
        vector_we_i      = 1'b0;
        vector_idx_i     = 2'(`IRQ_KEY);
        vector_addr_i    = '0;
        iret_i           = 1'b0;
        build_image();
        build_expected();
        rom_byte_i = image[0];
        scan1 = 8'($urandom);
        scan2 = scan1;
        while (scan2 == scan1)
        begin
            scan2 = 8'($urandom);
        end

        // Sequential run, key interrupt, a second key held off until return.
        rows[0] = make_row(1'b1, 1'b0, 8'h00, 1'b0, 2'd0, 1'b0, 8'h00);
        rows[1] = make_row(1'b0, 1'b0, 8'h00, 1'b0, 2'd1, 1'b0, 8'h00);
        rows[2] = make_row(1'b0, 1'b1, scan1, 1'b0, 2'd3, 1'b1, scan1);
        rows[3] = make_row(1'b0, 1'b1, scan2, 1'b1, 2'd2, 1'b0, scan1);
        rows[4] = make_row(1'b0, 1'b0, 8'h00, 1'b0, 2'd3, 1'b1, scan2);

        repeat (3) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        rst_n_i = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row              = rows[r];
            vector_we_i      = row.vec_we;
            vector_addr_i    = row.vec_addr;
            scancode_valid_i = row.send_scan;
            scancode_i       = row.scan;
            @(negedge CLOCK_50);
            vector_we_i      = 1'b0;
            scancode_valid_i = 1'b0;
            // The strobe lasts one cycle.
            compare_value("instr_valid_o", 32'(instr_valid_o), 32'h0);
            if (row.do_iret)
            begin
                repeat (IRET_GAP) @(negedge CLOCK_50);
                iret_i = 1'b1;
                @(negedge CLOCK_50);
                iret_i = 1'b0;
            end
            while (!instr_valid_o)
            begin
                @(negedge CLOCK_50);
            end
            compare_value("instr_ip_o", 32'(instr_ip_o), 32'(exp_ip[row.slot]));
            compare_value("instr_o.operation", 32'(instr_o.operation),
                          32'(exp_instr[row.slot].operation));
            compare_value("instr_o.operand1", instr_o.operand1,
                          exp_instr[row.slot].operand1);
            compare_value("instr_o.operand2", instr_o.operand2,
                          exp_instr[row.slot].operand2);
            compare_value("isr_active_o", 32'(isr_active_o), 32'(row.exp_active));
            compare_value("isr_value_o", isr_value_o, row.exp_value);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* cpu_frontend.f */
+incdir+hdl
hdl/cpu_frontend_pkg.sv
hdl/frontend_fsm.sv
hdl/byte_counter.sv
hdl/program_ram.sv
hdl/instr_assembler.sv
hdl/irq_queue.sv
hdl/ip_unit.sv
hdl/cpu_frontend.sv
sim/tb_cpu_frontend.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_cpu_frontend -f cpu_frontend.f
./obj_dir/Vtb_cpu_frontend
